// ==== logic/sa_pkg.sv ====
package sa_pkg;

  // Array shape
  localparam int R = 4;
  localparam int C = 4;

  // Element widths
  localparam int WX = 8;
  localparam int WK = 8;
  localparam int WA = 8;

  // Accumulator width, all sums wrap at this size
  localparam int WY = 20;

  localparam int COL_W = (C > 1) ? $clog2(C) : 1;

  typedef logic signed [WX-1:0] x_elem_t;
  typedef logic signed [WK-1:0] k_elem_t;
  typedef logic signed [WA-1:0] a_elem_t;
  typedef logic signed [WY-1:0] y_elem_t;

  // One element per row
  typedef x_elem_t [R-1:0] x_vec_t;
  typedef a_elem_t [R-1:0] a_vec_t;
  typedef y_elem_t [R-1:0] y_vec_t;

  // One element per column
  typedef k_elem_t [C-1:0] k_vec_t;

  // Column first, then row
  typedef y_elem_t [C-1:0][R-1:0] y_grid_t;

  typedef logic [COL_W-1:0] col_idx_t;

  typedef enum logic [1:0] {
    BANK_EMPTY,
    BANK_LOAD,
    BANK_SEND
  } bank_state_t;

endpackage

// ==== logic/sa_feed.sv ====
module sa_feed (
  input  logic            clk,
  input  logic            arst_n,

  input  logic            k_valid,
  output logic            k_ready,
  input  sa_pkg::k_vec_t  k_data,
  input  logic            k_last,

  input  logic            x_valid,
  output logic            x_ready,
  input  sa_pkg::x_vec_t  x_data,
  input  logic            x_last,

  input  logic            bank_full,

  output sa_pkg::x_vec_t  x_q,
  output sa_pkg::k_vec_t  k_q,
  output logic            acc_en,
  output logic            acc_clr,
  output logic            acc_last
);

  logic join_valid;
  logic join_ready;
  logic join_last;
  logic accept;
  logic first_q;

  // Both streams must offer a beat before either transfers
  assign join_valid = k_valid & x_valid;
  assign join_last  = k_last & x_last;

  // acc_last doubles as the bubble after a packet end
  assign join_ready = !acc_last && !(join_last && bank_full);

  assign k_ready = join_ready & x_valid;
  assign x_ready = join_ready & k_valid;
  assign accept  = join_valid & join_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_en   <= 1'b0;
      acc_clr  <= 1'b0;
      acc_last <= 1'b0;
      first_q  <= 1'b1;
    end else begin
      acc_en   <= accept;
      acc_clr  <= accept & first_q;
      acc_last <= accept & join_last;
      if (accept) begin
        // Next beat opens a new packet
        first_q <= join_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      x_q <= x_data;
      k_q <= k_data;
    end
  end

  // Grid clear only ever comes with an accumulate
  a_clr_with_en : assert property (
    @(posedge clk) disable iff (!arst_n)
    acc_clr |-> acc_en
  );

  // k and x move as one joined beat
  a_joined_xfer : assert property (
    @(posedge clk) disable iff (!arst_n)
    (k_valid && k_ready) == (x_valid && x_ready)
  );

endmodule

// ==== logic/sa_column.sv ====
module sa_column (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             acc_en,
  input  logic             acc_clr,
  input  sa_pkg::x_vec_t   x_q,
  input  sa_pkg::k_elem_t  k_elem,
  output sa_pkg::y_vec_t   sums
);

  import sa_pkg::*;

  y_vec_t prod;
  y_vec_t acc_q;

  // Shared weight times each pixel, widened before the multiply
  always_comb begin
    for (int r = 0; r < R; r++) begin
      prod[r] = y_elem_t'(x_q[r]) * y_elem_t'(k_elem);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_q <= '0;
    end else if (acc_en) begin
      for (int r = 0; r < R; r++) begin
        if (acc_clr) begin
          acc_q[r] <= prod[r];
        end else begin
          acc_q[r] <= acc_q[r] + prod[r];
        end
      end
    end
  end

  assign sums = acc_q;

endmodule

// ==== logic/sa_drain.sv ====
module sa_drain (
  input  logic             clk,
  input  logic             arst_n,

  input  logic             acc_last,
  input  sa_pkg::y_grid_t  col_sums,
  output logic             bank_full,

  input  logic             a_valid,
  output logic             a_ready,
  input  sa_pkg::a_vec_t   a_data,

  output logic             y_valid,
  input  logic             y_ready,
  output sa_pkg::y_vec_t   y_data,
  output logic             y_last
);

  import sa_pkg::*;

  bank_state_t state_q;
  col_idx_t    col_q;
  y_grid_t     bank_q;
  logic        sending;
  logic        y_xfer;

  assign sending = (state_q == BANK_SEND);

  // Bank counts as taken from the moment a packet end is seen
  assign bank_full = (state_q != BANK_EMPTY);

  // Join the partial sum stream onto the current bank column
  assign y_valid = sending & a_valid;
  assign a_ready = sending & y_ready;
  assign y_last  = sending && (col_q == col_idx_t'(C - 1));
  assign y_xfer  = y_valid & y_ready;

  always_comb begin
    for (int r = 0; r < R; r++) begin
      y_data[r] = bank_q[col_q][r] + y_elem_t'(a_data[r]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= BANK_EMPTY;
      col_q   <= '0;
    end else begin
      case (state_q)
        BANK_EMPTY: begin
          if (acc_last) begin
            state_q <= BANK_LOAD;
          end
        end
        BANK_LOAD: begin
          // Grid holds the final sums by now
          state_q <= BANK_SEND;
          col_q   <= '0;
        end
        BANK_SEND: begin
          if (y_xfer) begin
            col_q <= col_q + col_idx_t'(1);
            if (y_last) begin
              state_q <= BANK_EMPTY;
            end
          end
        end
        default: begin
          state_q <= BANK_EMPTY;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == BANK_LOAD) begin
      bank_q <= col_sums;
    end
  end

  // Beat held under back-pressure, needs the a source to hold too
  a_y_hold : assert property (
    @(posedge clk) disable iff (!arst_n)
    (y_valid && !y_ready) |=> (y_valid && $stable(y_data) && $stable(y_last))
  );

  // Feed hold-off keeps a second packet end out of the load slot
  a_no_last_in_load : assert property (
    @(posedge clk) disable iff (!arst_n)
    acc_last |-> (state_q != BANK_LOAD)
  );

endmodule

// ==== logic/sa_top.sv ====
module sa_top (
  input  logic            clk,
  input  logic            arst_n,

  input  logic            k_valid,
  output logic            k_ready,
  input  sa_pkg::k_vec_t  k_data,
  input  logic            k_last,

  input  logic            x_valid,
  output logic            x_ready,
  input  sa_pkg::x_vec_t  x_data,
  input  logic            x_last,

  input  logic            a_valid,
  output logic            a_ready,
  input  sa_pkg::a_vec_t  a_data,

  output logic            y_valid,
  input  logic            y_ready,
  output sa_pkg::y_vec_t  y_data,
  output logic            y_last
);

  import sa_pkg::*;

  x_vec_t  x_q;
  k_vec_t  k_q;
  logic    acc_en;
  logic    acc_clr;
  logic    acc_last;
  logic    bank_full;
  y_grid_t col_sums;

  sa_feed i_feed (
    .clk       (clk),
    .arst_n    (arst_n),
    .k_valid   (k_valid),
    .k_ready   (k_ready),
    .k_data    (k_data),
    .k_last    (k_last),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .x_data    (x_data),
    .x_last    (x_last),
    .bank_full (bank_full),
    .x_q       (x_q),
    .k_q       (k_q),
    .acc_en    (acc_en),
    .acc_clr   (acc_clr),
    .acc_last  (acc_last)
  );

  // Column c takes weight element c
  for (genvar c = 0; c < C; c++) begin : g_col
    sa_column i_col (
      .clk     (clk),
      .arst_n  (arst_n),
      .acc_en  (acc_en),
      .acc_clr (acc_clr),
      .x_q     (x_q),
      .k_elem  (k_q[c]),
      .sums    (col_sums[c])
    );
  end

  sa_drain i_drain (
    .clk       (clk),
    .arst_n    (arst_n),
    .acc_last  (acc_last),
    .col_sums  (col_sums),
    .bank_full (bank_full),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_data    (a_data),
    .y_valid   (y_valid),
    .y_ready   (y_ready),
    .y_data    (y_data),
    .y_last    (y_last)
  );

endmodule

// ==== dv/sa_tb_util.svh ====
`ifndef SA_TB_UTIL_SVH
`define SA_TB_UTIL_SVH

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v = {v[30:0], lfsr_q[0]};
  end
  return v;
endfunction

// Mode 0 always offers, otherwise three cycles in four
function automatic logic stream_go(input int mode);
  if (mode == 0) begin
    return 1'b1;
  end
  return (rand_bits(2) != 32'd0);
endfunction

function automatic void note_error();
  errors++;
  test_errors++;
endfunction

function automatic void refresh_head();
  exp_avail = (exp_data_q.size() > 0);
  if (exp_avail) begin
    exp_data = exp_data_q[0];
    exp_last = exp_last_q[0];
  end
endfunction

// Builds one packet of stimulus and its expected y beats
task automatic add_packet(input int len);
  int     acc [C][R];
  k_vec_t k;
  x_vec_t x;
  a_vec_t a;
  y_vec_t y;
  for (int c = 0; c < C; c++) begin
    for (int r = 0; r < R; r++) begin
      acc[c][r] = 0;
    end
  end
  for (int b = 0; b < len; b++) begin
    for (int c = 0; c < C; c++) begin
      k[c] = k_elem_t'(rand_bits(WK));
    end
    for (int r = 0; r < R; r++) begin
      x[r] = x_elem_t'(rand_bits(WX));
    end
    // Outer product of this beat
    for (int c = 0; c < C; c++) begin
      for (int r = 0; r < R; r++) begin
        acc[c][r] += int'(k[c]) * int'(x[r]);
      end
    end
    k_beats_q.push_back(k);
    x_beats_q.push_back(x);
    last_beats_q.push_back(b == len - 1);
  end
  // Column-major output, wrapped to the accumulator width
  for (int c = 0; c < C; c++) begin
    for (int r = 0; r < R; r++) begin
      a[r] = a_elem_t'(rand_bits(WA));
      y[r] = y_elem_t'(acc[c][r] + int'(a[r]));
    end
    a_beats_q.push_back(a);
    exp_data_q.push_back(y);
    exp_last_q.push_back(c == C - 1);
    exp_total++;
  end
endtask

`endif

// ==== dv/sa_tb.sv ====
module sa_tb;

  import sa_pkg::*;

  localparam int SINGLE_PKTS = 1;
  localparam int SINGLE_LEN  = 1;
  localparam int MULTI_PKTS  = 4;
  localparam int MULTI_LEN   = 6;
  localparam int STALL_PKTS  = 4;
  localparam int STALL_LEN   = 5;
  localparam int B2B_PKTS    = 6;
  localparam int B2B_LEN     = 2;
  localparam int SKEW_PKTS   = 4;
  localparam int SKEW_LEN    = 4;

  // Joined input beats plus y beats over all tests
  localparam int TOTAL_BEATS = SINGLE_PKTS * (SINGLE_LEN + C) + MULTI_PKTS * (MULTI_LEN + C)
                             + STALL_PKTS * (STALL_LEN + C) + B2B_PKTS * (B2B_LEN + C)
                             + SKEW_PKTS * (SKEW_LEN + C);
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_BEATS + 200;

  logic   clk;
  logic   arst_n;
  logic   k_valid;
  logic   k_ready;
  k_vec_t k_data;
  logic   k_last;
  logic   x_valid;
  logic   x_ready;
  x_vec_t x_data;
  logic   x_last;
  logic   a_valid;
  logic   a_ready;
  a_vec_t a_data;
  logic   y_valid;
  logic   y_ready;
  y_vec_t y_data;
  logic   y_last;

  logic [15:0] lfsr_q = 16'd35142;
  k_vec_t      k_beats_q[$];
  x_vec_t      x_beats_q[$];
  logic        last_beats_q[$];
  a_vec_t      a_beats_q[$];
  y_vec_t      exp_data_q[$];
  logic        exp_last_q[$];
  y_vec_t      exp_data = '0;
  logic        exp_last = 1'b0;
  logic        exp_avail = 1'b0;
  logic        stim_started = 1'b0;
  string       test_name = "reset_idle";
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          exp_total = 0;
  int          y_rx_total = 0;
  int          cycle_cnt = 0;

  `include "sa_tb_util.svh"

  sa_top i_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .k_valid (k_valid),
    .k_ready (k_ready),
    .k_data  (k_data),
    .k_last  (k_last),
    .x_valid (x_valid),
    .x_ready (x_ready),
    .x_data  (x_data),
    .x_last  (x_last),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .a_data  (a_data),
    .y_valid (y_valid),
    .y_ready (y_ready),
    .y_data  (y_data),
    .y_last  (y_last)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  a_y_data : assert property (@(posedge clk) disable iff (!arst_n)
    (y_valid && y_ready && exp_avail) |-> (y_data == exp_data))
    else begin
      $display("MISMATCH %s y_data expected=%h actual=%h", test_name, exp_data,
               $sampled(y_data));
      note_error();
    end

  a_y_last : assert property (@(posedge clk) disable iff (!arst_n)
    (y_valid && y_ready && exp_avail) |-> (y_last == exp_last))
    else begin
      $display("MISMATCH %s y_last expected=%b actual=%b", test_name, exp_last,
               $sampled(y_last));
      note_error();
    end

  a_y_expected : assert property (@(posedge clk) disable iff (!arst_n)
    (y_valid && y_ready) |-> exp_avail)
    else begin
      $display("%s: a y beat arrived when none was expected", test_name);
      note_error();
    end

  a_y_hold : assert property (@(posedge clk) disable iff (!arst_n)
    (y_valid && !y_ready) |=> (y_valid && $stable(y_data) && $stable(y_last)))
    else begin
      $display("%s: a stalled y beat changed or was dropped", test_name);
      note_error();
    end

  a_idle : assert property (@(posedge clk) disable iff (!arst_n)
    !stim_started |-> (!y_valid && !k_ready && !x_ready))
    else begin
      $display("%s: handshake active before any stimulus", test_name);
      note_error();
    end

  a_kx_joined : assert property (@(posedge clk) disable iff (!arst_n)
    (k_valid && k_ready) == (x_valid && x_ready))
    else begin
      $display("%s: k and x transferred on different cycles", test_name);
      note_error();
    end

  a_ay_joined : assert property (@(posedge clk) disable iff (!arst_n)
    (a_valid && a_ready) == (y_valid && y_ready))
    else begin
      $display("%s: a and y transferred on different cycles", test_name);
      note_error();
    end

  // Every y transfer the DUT makes, expected or not
  always @(posedge clk) begin
    if (arst_n && y_valid && y_ready) begin
      y_rx_total++;
    end
  end

  // Called on a falling edge, returns on a falling edge
  task automatic run_test(input string name, input int pkts, input int len,
                          input int kx_mode, input int a_mode, input int y_mode);
    logic kx_fire;
    logic a_fire;
    logic y_fire;
    int   cyc;
    test_name = name;
    test_errors = 0;
    stim_started = 1'b1;
    for (int p = 0; p < pkts; p++) begin
      add_packet(len);
    end
    refresh_head();
    cyc = 0;
    while (exp_data_q.size() > 0) begin
      if (k_beats_q.size() > 0) begin
        // Mode 2 raises k and x independently
        if (kx_mode == 2) begin
          if (!k_valid) k_valid = stream_go(1);
          if (!x_valid) x_valid = stream_go(1);
        end else if (!k_valid) begin
          k_valid = stream_go(kx_mode);
          x_valid = k_valid;
        end
        k_data = k_beats_q[0];
        x_data = x_beats_q[0];
        k_last = last_beats_q[0];
        x_last = last_beats_q[0];
      end
      if (a_beats_q.size() > 0) begin
        if (!a_valid) a_valid = stream_go(a_mode);
        a_data = a_beats_q[0];
      end
      case (y_mode)
        0: y_ready = 1'b1;
        1: y_ready = stream_go(1);
        default: y_ready = (cyc >= 16);
      endcase
      @(posedge clk);
      kx_fire = k_valid && k_ready;
      a_fire = a_valid && a_ready;
      y_fire = y_valid && y_ready;
      @(negedge clk);
      if (kx_fire) begin
        void'(k_beats_q.pop_front());
        void'(x_beats_q.pop_front());
        void'(last_beats_q.pop_front());
        k_valid = 1'b0;
        x_valid = 1'b0;
      end
      if (a_fire) begin
        void'(a_beats_q.pop_front());
        a_valid = 1'b0;
      end
      if (y_fire) begin
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
      end
      refresh_head();
      cyc++;
    end
    tests_run++;
    $display("%s: %0d packets, %0d cycles, %0d errors", name, pkts, cyc, test_errors);
  endtask

  initial begin
    arst_n = 1'b0;
    k_valid = 1'b0;
    k_data = '0;
    k_last = 1'b0;
    x_valid = 1'b0;
    x_data = '0;
    x_last = 1'b0;
    a_valid = 1'b0;
    a_data = '0;
    y_ready = 1'b0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    // Idle check runs in the assertions
    repeat (4) @(negedge clk);
    tests_run++;
    $display("%s: 0 packets, 4 cycles, %0d errors", test_name, test_errors);
    run_test("single_beat", SINGLE_PKTS, SINGLE_LEN, 0, 0, 0);
    run_test("multi_beat", MULTI_PKTS, MULTI_LEN, 1, 1, 0);
    run_test("y_stall", STALL_PKTS, STALL_LEN, 1, 1, 1);
    run_test("back_to_back", B2B_PKTS, B2B_LEN, 0, 0, 2);
    run_test("skewed_valid", SKEW_PKTS, SKEW_LEN, 2, 1, 1);
    repeat (4) @(negedge clk);
    assert (y_rx_total == exp_total) else begin
      $display("Received %0d y beats but expected %0d", y_rx_total, exp_total);
      errors++;
    end
    $display("Tests %0d, y beats %0d of %0d, errors %0d", tests_run, y_rx_total, exp_total,
             errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout in %s after %0d cycles with %0d y beats outstanding", test_name,
             cycle_cnt, exp_data_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+dv
logic/sa_pkg.sv
logic/sa_feed.sv
logic/sa_column.sv
logic/sa_drain.sv
logic/sa_top.sv
dv/sa_tb.sv
